// ==== src/ifu_config.svh ====
//////////////////////////////////////////////////
// fetch subsystem constants, byte addresses throughout
// data width must be a power of two number of bytes
// error region runs from IFU_ERR_BASE to the top of memory
//////////////////////////////////////////////////
`ifndef IFU_CONFIG_SVH
`define IFU_CONFIG_SVH

`define IFU_ADDR_W        32            // instruction address width
`define IFU_DATA_W        32            // instruction word width
`define IFU_ID_W          2             // axi read id width
`define IFU_ADDR_Q_DEPTH  3             // outstanding reads in the master
`define IFU_ROM_Q_DEPTH   4             // rom request queue entries

`define IFU_RESET_PC      32'h0000_1000 // first fetch address
`define IFU_ERR_BASE      32'h0001_0000 // slverr at or above this
`define IFU_ROM_KEY       32'h5a5a_c3c3 // rom word = addr ^ key

`endif

// ==== src/ifu_pkg.sv ====
//////////////////////////////////////////////////
// shared fetch types, widths come from ifu_config.svh
// response codes follow the axi4 rresp encoding
//////////////////////////////////////////////////
`default_nettype none

`include "ifu_config.svh"

package ifu_pkg;

    // one instruction address and one instruction word
    typedef logic [`IFU_ADDR_W-1:0] inst_addr_t;
    typedef logic [`IFU_DATA_W-1:0] inst_word_t;

    // rresp codes, bit 1 set means the read failed
    typedef enum logic [1:0] {
        OKAY   = 2'b00,
        EXOKAY = 2'b01,  // exclusive ok, never produced here
        SLVERR = 2'b10,
        DECERR = 2'b11
    } axi_resp_e;

    // rom response sequencer
    typedef enum logic [1:0] {
        ROM_IDLE = 2'b00,  // nothing in service
        ROM_WAIT = 2'b01,  // counting down the latency
        ROM_RESP = 2'b10   // r channel presented, waiting for rready
    } rom_state_e;

endpackage

`default_nettype wire

// ==== src/ifu_pc_gen.sv ====
//////////////////////////////////////////////////
// fetch pc, steps one word per accepted read
// jump has priority over stall and back-pressure
// jump targets are expected to be word aligned
//////////////////////////////////////////////////
`timescale 1ns/10ps
`default_nettype none

`include "ifu_config.svh"

module ifu_pc_gen
    import ifu_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       stall_i,      // fetch held from outside
    input  logic       pc_stall_i,   // master cannot take the request
    input  logic       jump_i,       // single cycle redirect
    input  inst_addr_t jump_addr_i,
    output inst_addr_t pc_o
);

    // one instruction word in bytes
    localparam inst_addr_t PC_STEP = inst_addr_t'(`IFU_DATA_W / 8);

    inst_addr_t pc_q;
    inst_addr_t pc_d;
    logic       advance;

    // request goes out and is taken exactly when neither hold is up,
    // so that is the cycle the pc may move on
    assign advance = !stall_i && !pc_stall_i;

    always_comb begin
        pc_d = pc_q;  // default hold
        if (jump_i) begin
            pc_d = jump_addr_i;  // redirect wins
        end else if (advance) begin
            pc_d = pc_q + PC_STEP;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc_q <= `IFU_RESET_PC;
        end else begin
            pc_q <= pc_d;
        end
    end

    assign pc_o = pc_q;  // straight to araddr in the master

endmodule

`default_nettype wire

// ==== src/ifu_axi_master.sv ====
//////////////////////////////////////////////////
// single-beat axi read master for instruction fetch
// up to IFU_ADDR_Q_DEPTH reads in flight, in order only
// a jump bumps arid, older responses are then dropped
// an error response stalls the stream until the next jump
//////////////////////////////////////////////////
`timescale 1ns/10ps
`default_nettype none

`include "ifu_config.svh"

module ifu_axi_master
    import ifu_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 stall_axi_i,        // no new fetch, no response taken
    input  logic                 jump_flag_i,        // flush and switch id
    input  inst_addr_t           pc_i,
    output logic                 read_resp_error_o,  // sticky until reset
    output inst_word_t           inst_data_o,
    output inst_addr_t           inst_addr_o,
    output logic                 inst_valid_o,
    output logic                 pc_stall_o,
    // ar channel
    output logic [`IFU_ID_W-1:0] m_axi_arid_o,
    output inst_addr_t           m_axi_araddr_o,
    output logic                 m_axi_arvalid_o,
    input  logic                 m_axi_arready_i,
    // r channel
    input  logic [`IFU_ID_W-1:0] m_axi_rid_i,
    input  inst_word_t           m_axi_rdata_i,
    input  axi_resp_e            m_axi_rresp_i,
    input  logic                 m_axi_rvalid_i,
    output logic                 m_axi_rready_o
);

    localparam int unsigned QD      = `IFU_ADDR_Q_DEPTH;
    localparam int unsigned PTR_W   = $clog2(QD);
    localparam int unsigned CNT_W   = $clog2(QD + 1);
    // arsize for a full data word, arlen 0 and incr are implied by the slave
    localparam int unsigned AR_SIZE = $clog2(`IFU_DATA_W / 8);

    logic [`IFU_ID_W-1:0] arid_q;
    logic                 err_q;

    // address queue, one entry per outstanding read
    inst_addr_t           addr_q [QD];
    logic [PTR_W-1:0]     rd_ptr;
    logic [PTR_W-1:0]     wr_ptr;
    logic [CNT_W-1:0]     q_count;
    logic                 q_empty;
    logic                 q_full;

    logic                 ar_hs;
    logic                 rsp_hs;
    logic                 rsp_err;
    logic                 rid_match;
    logic                 valid_resp;
    logic                 err_hit;
    logic                 same_cycle_resp;
    logic                 push;
    logic                 pop;

    // wrap at depth, depth need not be a power of two
    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
        return (p == PTR_W'(QD - 1)) ? '0 : p + 1'b1;
    endfunction

    assign q_empty = (q_count == '0);
    assign q_full  = (q_count == CNT_W'(QD));

    // ar channel, address taken straight from the pc
    assign m_axi_arid_o    = arid_q;
    assign m_axi_araddr_o  = {pc_i[`IFU_ADDR_W-1:AR_SIZE], {AR_SIZE{1'b0}}};
    assign m_axi_arvalid_o = !stall_axi_i && !q_full;
    assign m_axi_rready_o  = !stall_axi_i;  // stall also holds off responses

    assign ar_hs     = m_axi_arvalid_o && m_axi_arready_i;
    assign rsp_hs    = m_axi_rvalid_i && m_axi_rready_o;
    assign rsp_err   = (m_axi_rresp_i == SLVERR) || (m_axi_rresp_i == DECERR);
    assign rid_match = (m_axi_rid_i == arid_q);  // stale ids fall out here

    // good beat of the current stream, nothing passes in a jump cycle
    assign valid_resp = rsp_hs && rid_match && !rsp_err && !jump_flag_i;
    assign err_hit    = rsp_hs && rid_match && rsp_err && !jump_flag_i;

    // response for the read issued this very cycle, queue bypassed
    assign same_cycle_resp = ar_hs && valid_resp && q_empty;

    assign push = ar_hs && !same_cycle_resp;
    assign pop  = !stall_axi_i && !q_empty && valid_resp;

    // pc only moves once the read has actually been taken
    assign pc_stall_o = (m_axi_arvalid_o && !m_axi_arready_i) || q_full;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            arid_q  <= '0;
            err_q   <= 1'b0;
            rd_ptr  <= '0;
            wr_ptr  <= '0;
            q_count <= '0;
        end else begin
            if (err_hit) begin
                err_q <= 1'b1;  // sticky
            end
            if (jump_flag_i) begin
                arid_q  <= arid_q + 1'b1;  // wraps, old stream now mismatches
                rd_ptr  <= '0;
                wr_ptr  <= '0;
                q_count <= '0;
            end else begin
                if (push) begin
                    wr_ptr <= ptr_inc(wr_ptr);
                end
                if (pop) begin
                    rd_ptr <= ptr_inc(rd_ptr);
                end
                if (push && !pop) begin
                    q_count <= q_count + 1'b1;
                end else if (pop && !push) begin
                    q_count <= q_count - 1'b1;
                end
            end
        end
    end

    // queue storage
    always_ff @(posedge clk) begin
        if (push && !jump_flag_i) begin
            addr_q[wr_ptr] <= m_axi_araddr_o;
        end
    end

    assign read_resp_error_o = err_q;
    assign inst_data_o       = m_axi_rdata_i;  // data is not buffered
    assign inst_addr_o       = !q_empty        ? addr_q[rd_ptr] :
                               same_cycle_resp ? m_axi_araddr_o : '0;
    assign inst_valid_o      = valid_resp;

endmodule

`default_nettype wire

// ==== src/ifu_inst_rom.sv ====
//////////////////////////////////////////////////
// behavioral rom, axi read slave, single beat only
// word = address ^ IFU_ROM_KEY, slverr from IFU_ERR_BASE up
// latency 1 to 4 cycles from an lfsr, responses in order
//////////////////////////////////////////////////
`timescale 1ns/10ps
`default_nettype none

`include "ifu_config.svh"

module ifu_inst_rom
    import ifu_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst_n,
    // ar channel
    input  logic [`IFU_ID_W-1:0] s_axi_arid_i,
    input  inst_addr_t           s_axi_araddr_i,
    input  logic                 s_axi_arvalid_i,
    output logic                 s_axi_arready_o,
    // r channel
    output logic [`IFU_ID_W-1:0] s_axi_rid_o,
    output inst_word_t           s_axi_rdata_o,
    output axi_resp_e            s_axi_rresp_o,
    output logic                 s_axi_rvalid_o,
    input  logic                 s_axi_rready_i
);

    localparam int unsigned QD    = `IFU_ROM_Q_DEPTH;
    localparam int unsigned PTR_W = $clog2(QD);
    localparam int unsigned CNT_W = $clog2(QD + 1);

    // request queue, id and address side by side
    logic [`IFU_ID_W-1:0] qid   [QD];
    inst_addr_t           qaddr [QD];
    logic [PTR_W-1:0]     rd_ptr;
    logic [PTR_W-1:0]     wr_ptr;
    logic [CNT_W-1:0]     q_count;
    logic                 q_empty;
    logic                 q_full;
    logic                 push;

    rom_state_e           state_q;
    logic [1:0]           wait_q;    // extra cycles left in ROM_WAIT
    logic [7:0]           lfsr_q;
    logic                 lfsr_fb;
    logic                 start;     // head of queue enters service
    logic                 resp_done;

    // request in service
    logic [`IFU_ID_W-1:0] rid_q;
    inst_addr_t           raddr_q;

    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
        return (p == PTR_W'(QD - 1)) ? '0 : p + 1'b1;
    endfunction

    assign q_empty         = (q_count == '0);
    assign q_full          = (q_count == CNT_W'(QD));
    assign s_axi_arready_o = !q_full;
    assign push            = s_axi_arvalid_i && s_axi_arready_o;

    // next request may start in the same edge the last one is taken
    assign resp_done = (state_q == ROM_RESP) && s_axi_rready_i;
    assign start     = !q_empty && ((state_q == ROM_IDLE) || resp_done);

    // x^8 + x^6 + x^5 + x^4 + 1
    assign lfsr_fb = lfsr_q[7] ^ lfsr_q[5] ^ lfsr_q[4] ^ lfsr_q[3];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rd_ptr  <= '0;
            wr_ptr  <= '0;
            q_count <= '0;
            state_q <= ROM_IDLE;
            wait_q  <= '0;
            lfsr_q  <= 8'ha5;  // any nonzero seed
        end else begin
            lfsr_q <= {lfsr_q[6:0], lfsr_fb};  // free running
            if (push) begin
                wr_ptr <= ptr_inc(wr_ptr);
            end
            if (start) begin
                rd_ptr <= ptr_inc(rd_ptr);
            end
            if (push && !start) begin
                q_count <= q_count + 1'b1;
            end else if (start && !push) begin
                q_count <= q_count - 1'b1;
            end

            unique case (state_q)
                ROM_IDLE, ROM_RESP: begin
                    if (start) begin
                        // zero draw goes straight to the r channel
                        state_q <= (lfsr_q[1:0] == 2'd0) ? ROM_RESP : ROM_WAIT;
                        wait_q  <= lfsr_q[1:0] - 2'd1;
                    end else if (resp_done) begin
                        state_q <= ROM_IDLE;
                    end
                end
                ROM_WAIT: begin
                    if (wait_q == 2'd0) begin
                        state_q <= ROM_RESP;
                    end else begin
                        wait_q <= wait_q - 2'd1;
                    end
                end
                default: state_q <= ROM_IDLE;
            endcase
        end
    end

    // queue storage and response payload
    always_ff @(posedge clk) begin
        if (push) begin
            qid[wr_ptr]   <= s_axi_arid_i;
            qaddr[wr_ptr] <= s_axi_araddr_i;
        end
        if (start) begin
            rid_q   <= qid[rd_ptr];   // id echoed back unchanged
            raddr_q <= qaddr[rd_ptr];
        end
    end

    // payload only changes on start, so r stays put until rready
    assign s_axi_rvalid_o = (state_q == ROM_RESP);
    assign s_axi_rid_o    = rid_q;
    assign s_axi_rdata_o  = raddr_q ^ `IFU_ROM_KEY;
    assign s_axi_rresp_o  = (raddr_q >= `IFU_ERR_BASE) ? SLVERR : OKAY;

endmodule

`default_nettype wire

// ==== src/ifu_fetch_top.sv ====
//////////////////////////////////////////////////
// fetch front end, pc generator + axi master + rom
// stall_i and jump_i go to both pc and master
//////////////////////////////////////////////////
`timescale 1ns/10ps
`default_nettype none

`include "ifu_config.svh"

module ifu_fetch_top
    import ifu_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       stall_i,
    input  logic       jump_i,
    input  inst_addr_t jump_addr_i,
    output logic       inst_valid_o,
    output inst_addr_t inst_addr_o,
    output inst_word_t inst_data_o,
    output logic       read_resp_error_o
);

    inst_addr_t           pc;
    logic                 pc_stall;  // back-pressure from the master

    // master to rom
    logic [`IFU_ID_W-1:0] ar_id;
    inst_addr_t           ar_addr;
    logic                 ar_valid;
    logic                 ar_ready;
    logic [`IFU_ID_W-1:0] r_id;
    inst_word_t           r_data;
    axi_resp_e            r_resp;
    logic                 r_valid;
    logic                 r_ready;

    ifu_pc_gen u_pc_gen (
        .clk         (clk),
        .rst_n       (rst_n),
        .stall_i     (stall_i),
        .pc_stall_i  (pc_stall),
        .jump_i      (jump_i),
        .jump_addr_i (jump_addr_i),
        .pc_o        (pc)
    );

    ifu_axi_master u_axi_master (
        .clk               (clk),
        .rst_n             (rst_n),
        .stall_axi_i       (stall_i),
        .jump_flag_i       (jump_i),
        .pc_i              (pc),
        .read_resp_error_o (read_resp_error_o),
        .inst_data_o       (inst_data_o),
        .inst_addr_o       (inst_addr_o),
        .inst_valid_o      (inst_valid_o),
        .pc_stall_o        (pc_stall),
        .m_axi_arid_o      (ar_id),
        .m_axi_araddr_o    (ar_addr),
        .m_axi_arvalid_o   (ar_valid),
        .m_axi_arready_i   (ar_ready),
        .m_axi_rid_i       (r_id),
        .m_axi_rdata_i     (r_data),
        .m_axi_rresp_i     (r_resp),
        .m_axi_rvalid_i    (r_valid),
        .m_axi_rready_o    (r_ready)
    );

    ifu_inst_rom u_inst_rom (
        .clk             (clk),
        .rst_n           (rst_n),
        .s_axi_arid_i    (ar_id),
        .s_axi_araddr_i  (ar_addr),
        .s_axi_arvalid_i (ar_valid),
        .s_axi_arready_o (ar_ready),
        .s_axi_rid_o     (r_id),
        .s_axi_rdata_o   (r_data),
        .s_axi_rresp_o   (r_resp),
        .s_axi_rvalid_o  (r_valid),
        .s_axi_rready_i  (r_ready)
    );

endmodule

`default_nettype wire

// ==== verif/ifu_fetch_asserts.sv ====
//////////////////////////////////////////////////
// axi channel and queue checks for the fetch path
// bound into the master (full set) and the rom (r + queue)
// a jump may redirect a pending ar request
//////////////////////////////////////////////////
`timescale 1ns/10ps
`default_nettype none

`include "ifu_config.svh"

module ifu_fetch_asserts
    import ifu_pkg::*;
#(
    parameter int unsigned Q_MAX = 3,  // deepest legal queue fill
    parameter int unsigned CNT_W = 2   // width of the bound queue counter
) (
    input logic                 clk,
    input logic                 rst_n,
    input logic                 arvalid_i,
    input logic                 arready_i,
    input logic [`IFU_ID_W-1:0] arid_i,
    input inst_addr_t           araddr_i,
    input logic                 rvalid_i,
    input logic                 rready_i,
    input logic [`IFU_ID_W-1:0] rid_i,
    input inst_word_t           rdata_i,
    input axi_resp_e            rresp_i,
    input logic [CNT_W-1:0]     q_count_i,
    input logic                 flush_i,   // jump in this cycle
    input logic                 valid_i,   // instruction beat out
    input logic                 stall_i
);

    // held request keeps address and id
    ar_stable: assert property (@(posedge clk) disable iff (!rst_n)
        arvalid_i && !arready_i && !flush_i |=> $stable(araddr_i) && $stable(arid_i))
        else $error("ar payload moved while arready was low");

    // slave keeps r channel up and unchanged until rready
    r_stable: assert property (@(posedge clk) disable iff (!rst_n)
        rvalid_i && !rready_i |=> rvalid_i && $stable(rdata_i) && $stable(rid_i)
            && $stable(rresp_i))
        else $error("r channel changed before rready");

    q_bound: assert property (@(posedge clk) disable iff (!rst_n)
        q_count_i <= CNT_W'(Q_MAX))
        else $error("queue count above its depth");

    no_beat_in_stall: assert property (@(posedge clk) disable iff (!rst_n)
        !(valid_i && stall_i))
        else $error("instruction beat during stall");

endmodule

bind ifu_axi_master ifu_fetch_asserts #(
    .Q_MAX (`IFU_ADDR_Q_DEPTH),
    .CNT_W ($clog2(`IFU_ADDR_Q_DEPTH + 1))
) master_chk (
    .clk       (clk),
    .rst_n     (rst_n),
    .arvalid_i (m_axi_arvalid_o),
    .arready_i (m_axi_arready_i),
    .arid_i    (m_axi_arid_o),
    .araddr_i  (m_axi_araddr_o),
    .rvalid_i  (m_axi_rvalid_i),
    .rready_i  (m_axi_rready_o),
    .rid_i     (m_axi_rid_i),
    .rdata_i   (m_axi_rdata_i),
    .rresp_i   (m_axi_rresp_i),
    .q_count_i (q_count),
    .flush_i   (jump_flag_i),
    .valid_i   (inst_valid_o),
    .stall_i   (stall_axi_i)
);

// rom side, ar check left to the master which sees the jump
bind ifu_inst_rom ifu_fetch_asserts #(
    .Q_MAX (`IFU_ROM_Q_DEPTH),
    .CNT_W ($clog2(`IFU_ROM_Q_DEPTH + 1))
) rom_chk (
    .clk       (clk),
    .rst_n     (rst_n),
    .arvalid_i (1'b0),
    .arready_i (s_axi_arready_o),
    .arid_i    (s_axi_arid_i),
    .araddr_i  (s_axi_araddr_i),
    .rvalid_i  (s_axi_rvalid_o),
    .rready_i  (s_axi_rready_i),
    .rid_i     (s_axi_rid_o),
    .rdata_i   (s_axi_rdata_o),
    .rresp_i   (s_axi_rresp_o),
    .q_count_i (q_count),
    .flush_i   (1'b0),
    .valid_i   (1'b0),
    .stall_i   (1'b0)
);

`default_nettype wire

// ==== verif/ifu_fetch_tb.sv ====
//////////////////////////////////////////////////
// fetch front end testbench, 40 ns clock, inputs on the falling edge
// outputs sampled 10 ns after the falling edge, when settled
// expected word is addr ^ IFU_ROM_KEY from the config header
//////////////////////////////////////////////////
`timescale 1ns/10ps
`default_nettype none

`include "ifu_config.svh"

module ifu_fetch_tb
    import ifu_pkg::*;
();

    localparam int unsigned CLK_PERIOD = 40;
    localparam int unsigned SAMPLE_DLY = CLK_PERIOD / 4;
    localparam int unsigned STEP       = `IFU_DATA_W / 8;                 // bytes per word
    localparam int unsigned JUMP_WORDS = (`IFU_ERR_BASE - 32'h100) >> 2;  // headroom below err

    logic       clk;
    logic       rst_n;
    logic       stall;
    logic       jump;
    inst_addr_t jump_addr;
    logic       inst_valid;
    inst_addr_t inst_addr;
    inst_word_t inst_data;
    logic       resp_err;

    inst_addr_t  exp_addr;          // next address the stream must show
    int unsigned beat_count   = 0;
    int unsigned check_count  = 0;
    int unsigned error_count  = 0;
    int unsigned test_num     = 0;
    int unsigned failed_tests = 0;
    int unsigned test_errors  = 0;  // error count when the test began
    string       test_name;

    ifu_fetch_top dut_i (
        .clk               (clk),
        .rst_n             (rst_n),
        .stall_i           (stall),
        .jump_i            (jump),
        .jump_addr_i       (jump_addr),
        .inst_valid_o      (inst_valid),
        .inst_addr_o       (inst_addr),
        .inst_data_o       (inst_data),
        .read_resp_error_o (resp_err)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // rom contents by rule
    function automatic inst_word_t expected_word(input inst_addr_t addr);
        return addr ^ `IFU_ROM_KEY;
    endfunction

    task automatic note_failure(input string msg);
        $display("%s", msg);
        error_count = error_count + 1;
    endtask

    task automatic check_addr(input string name, input inst_addr_t got, input inst_addr_t exp);
        check_count = check_count + 1;
        if (got !== exp) begin
            $display("** Error: %s = 0x%h, expected 0x%h", name, got, exp);
            error_count = error_count + 1;
        end
    endtask

    task automatic check_word(input string name, input inst_word_t got, input inst_word_t exp);
        check_count = check_count + 1;
        if (got !== exp) begin
            $display("** Error: %s = 0x%h, expected 0x%h", name, got, exp);
            error_count = error_count + 1;
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        check_count = check_count + 1;
        if (got !== exp) begin
            $display("** Error: %s = 0x%h, expected 0x%h", name, got, exp);
            error_count = error_count + 1;
        end
    endtask

    task automatic start_test(input string name);
        test_name   = name;
        test_errors = error_count;
        test_num    = test_num + 1;
    endtask

    task automatic end_test();
        logic ok;
        ok = (error_count == test_errors);
        if (!ok) begin
            failed_tests = failed_tests + 1;
        end
        $display("[test %0d] %s: %s", test_num, test_name, ok ? "ok" : "FAILED");
    endtask

    // returns on a falling edge
    task automatic wait_beats(input int unsigned n, input int unsigned limit);
        int unsigned goal;
        int unsigned cycles;
        goal   = beat_count + n;
        cycles = 0;
        while (beat_count < goal && cycles < limit) begin
            @(negedge clk);
            cycles = cycles + 1;
        end
        if (beat_count < goal) begin
            note_failure($sformatf("timeout: %0d of %0d instructions arrived in %0d cycles",
                                   n - (goal - beat_count), n, limit));
        end
    endtask

    task automatic wait_error_flag(input int unsigned limit);
        int unsigned cycles;
        cycles = 0;
        while (!resp_err && cycles < limit) begin
            @(negedge clk);
            cycles = cycles + 1;
        end
        if (!resp_err) begin
            note_failure($sformatf("timeout: read error flag still low after %0d cycles", limit));
        end
    endtask

    // one cycle pulse, called on a falling edge
    task automatic jump_to(input inst_addr_t target);
        jump      = 1'b1;
        jump_addr = target;
        exp_addr  = target;  // first beat after the pulse
        @(negedge clk);
        jump      = 1'b0;
    endtask

    // compare process, one sample per cycle once out of reset
    initial begin
        forever begin
            @(negedge clk);
            #(SAMPLE_DLY);
            if (rst_n) begin
                if (stall && inst_valid) begin
                    note_failure("instruction beat seen while stall was high");
                end
                if (inst_valid) begin
                    if (inst_addr >= `IFU_ERR_BASE) begin
                        note_failure($sformatf("beat from the error region at 0x%h", inst_addr));
                    end
                    check_addr("inst_addr_o", inst_addr, exp_addr);
                    check_word("inst_data_o", inst_data, expected_word(exp_addr));
                    exp_addr   = exp_addr + STEP;
                    beat_count = beat_count + 1;
                end
            end
        end
    end

    initial begin
        int unsigned run;
        inst_addr_t  target;
        rst_n     = 1'b0;
        stall     = 1'b0;
        jump      = 1'b0;
        jump_addr = '0;
        exp_addr  = `IFU_RESET_PC;
        void'($urandom(37));

        start_test("reset state");
        repeat (7) begin
            @(negedge clk);
            check_flag("inst_valid_o", inst_valid, 1'b0);
            check_flag("read_resp_error_o", resp_err, 1'b0);
        end
        @(negedge clk);
        rst_n = 1'b1;  // 8 rising edges seen in reset
        @(negedge clk);
        check_flag("inst_valid_o", inst_valid, 1'b0);
        check_flag("read_resp_error_o", resp_err, 1'b0);
        end_test();

        start_test("sequential fetch");
        wait_beats(40, 400);
        end_test();

        start_test("random stall");
        repeat (12) begin
            stall = 1'b1;
            run   = 1 + $urandom % 6;
            repeat (run) @(negedge clk);
            stall = 1'b0;
            run   = 1 + $urandom % 8;
            repeat (run) @(negedge clk);
        end
        wait_beats(8, 200);  // stream picks up where it left
        end_test();

        start_test("jump");
        repeat (4) begin
            target = ($urandom % JUMP_WORDS) << 2;
            jump_to(target);
            wait_beats(8, 200);  // also drains the old id from the rom
        end
        end_test();

        start_test("error region");
        jump_to(`IFU_ERR_BASE - 32'd8);  // two good words, then the region
        wait_error_flag(200);
        check_addr("address after last good beat", exp_addr, `IFU_ERR_BASE);
        repeat (20) begin
            @(negedge clk);
            check_flag("read_resp_error_o", resp_err, 1'b1);
        end
        jump_to(`IFU_RESET_PC);  // restart below the region, flag is sticky
        wait_beats(6, 200);
        check_flag("read_resp_error_o", resp_err, 1'b1);
        end_test();

        $display("summary: %0d tests, %0d failed, %0d checks, %0d errors",
                 test_num, failed_tests, check_count, error_count);
        if (error_count == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== sim.f ====
+incdir+src
src/ifu_pkg.sv
src/ifu_pc_gen.sv
src/ifu_axi_master.sv
src/ifu_inst_rom.sv
src/ifu_fetch_top.sv
verif/ifu_fetch_asserts.sv
verif/ifu_fetch_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the fetch testbench with verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/10ps \
    -f sim.f --top-module ifu_fetch_tb -o ifu_fetch_sim
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

out=$(./obj_dir/ifu_fetch_sim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

# the run counts as good only if the testbench reported success
if echo "$out" | grep -q "ALL TESTS PASSED"; then
    exit 0
fi
echo "simulation did not report success"
exit 1
